//--- logic/exec_settings.svh
`ifndef EXEC_SETTINGS_SVH
`define EXEC_SETTINGS_SVH

`define EXEC_DATA_W 32 // Data path width
`define EXEC_REG_W 5 // Register address width

// Primary opcodes
`define EXEC_OP_RTYPE 6'h00
`define EXEC_OP_REGIMM 6'h01
`define EXEC_OP_BEQ 6'h04
`define EXEC_OP_BNE 6'h05
`define EXEC_OP_BGTZ 6'h07
`define EXEC_OP_ADDIU 6'h09
`define EXEC_OP_SLTI 6'h0a
`define EXEC_OP_SLTIU 6'h0b
`define EXEC_OP_ANDI 6'h0c
`define EXEC_OP_ORI 6'h0d
`define EXEC_OP_XORI 6'h0e
`define EXEC_OP_LUI 6'h0f

`define EXEC_RT_BLTZ 5'h00 // REGIMM selector in rt

// R-type funct codes
`define EXEC_FN_SLL 6'h00
`define EXEC_FN_SRL 6'h02
`define EXEC_FN_SRA 6'h03
`define EXEC_FN_SLLV 6'h04
`define EXEC_FN_SRLV 6'h06
`define EXEC_FN_SRAV 6'h07
`define EXEC_FN_JR 6'h08
`define EXEC_FN_MFHI 6'h10
`define EXEC_FN_MFLO 6'h12
`define EXEC_FN_MULT 6'h18
`define EXEC_FN_MULTU 6'h19
`define EXEC_FN_DIV 6'h1a
`define EXEC_FN_DIVU 6'h1b
`define EXEC_FN_ADDU 6'h21
`define EXEC_FN_SUBU 6'h23
`define EXEC_FN_AND 6'h24
`define EXEC_FN_OR 6'h25
`define EXEC_FN_XOR 6'h26
`define EXEC_FN_SLT 6'h2a
`define EXEC_FN_SLTU 6'h2b

`endif

//--- logic/exec_pkg.sv
`include "exec_settings.svh"

package exec_pkg;

	typedef enum logic [4:0] {
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_ADD,
		ALU_SUB,
		ALU_SLTU,
		ALU_SLT,
		ALU_SLL,
		ALU_SRL,
		ALU_SRA,
		ALU_LUI,
		ALU_BEQ,
		ALU_BNE,
		ALU_BLTZ,
		ALU_BGTZ,
		ALU_PASS_A, // JR hands rs through
		ALU_MULT,
		ALU_MULTU,
		ALU_DIV,
		ALU_DIVU,
		ALU_MFHI,
		ALU_MFLO,
		ALU_NOP
	} alu_op_t;

	typedef struct packed {
		logic [5:0] opcode;
		logic [`EXEC_REG_W-1:0] rs;
		logic [`EXEC_REG_W-1:0] rt;
		logic [`EXEC_REG_W-1:0] rd;
		logic [4:0] shamt;
		logic [5:0] funct;
	} r_fields_t;

	typedef struct packed {
		logic [5:0] opcode;
		logic [`EXEC_REG_W-1:0] rs;
		logic [`EXEC_REG_W-1:0] rt;
		logic [15:0] imm;
	} i_fields_t;

	// Same 32-bit word seen with either field layout
	typedef union packed {
		r_fields_t r;
		i_fields_t i;
	} instr_u;

	typedef struct packed {
		logic valid;
		alu_op_t op;
		logic [`EXEC_DATA_W-1:0] a;
		logic [`EXEC_DATA_W-1:0] b;
		logic [`EXEC_REG_W-1:0] dest;
		logic reg_write;
		logic illegal;
	} issue_t;

	typedef struct packed {
		logic valid;
		logic [`EXEC_DATA_W-1:0] value;
		logic [`EXEC_REG_W-1:0] dest;
		logic reg_write;
		logic zero;
		logic branch_taken;
		logic illegal;
	} result_t;

endpackage

//--- logic/alu_core.sv
`include "exec_settings.svh"

module alu_core import exec_pkg::*; (
	input alu_op_t op,
	input logic [`EXEC_DATA_W-1:0] a,
	input logic [`EXEC_DATA_W-1:0] b,
	output logic [`EXEC_DATA_W-1:0] y,
	output logic zero,
	output logic branch_taken
);

	localparam int DW = `EXEC_DATA_W;
	localparam int SH_W = $clog2(DW);

	logic [SH_W-1:0] sh;
	logic [DW-1:0] diff;
	logic lt_signed;
	logic lt_unsigned;

	assign sh = b[SH_W-1:0]; // Shift count from the low bits of b
	assign diff = a - b;
	assign lt_signed = $signed(a) < $signed(b);
	assign lt_unsigned = a < b;

	always_comb begin
		case (op)
			ALU_AND: y = a & b;
			ALU_OR: y = a | b;
			ALU_XOR: y = a ^ b;
			ALU_ADD: y = a + b;
			ALU_SUB: y = diff;
			ALU_SLTU: y = {{(DW-1){1'b0}}, lt_unsigned};
			ALU_SLT: y = {{(DW-1){1'b0}}, lt_signed};
			ALU_SLL: y = a << sh;
			ALU_SRL: y = a >> sh;
			ALU_SRA: y = $signed(a) >>> sh; // Fills with a's sign bit
			ALU_LUI: y = b << 16;
			ALU_BEQ, ALU_BNE: y = diff; // Difference drives zero
			ALU_BLTZ, ALU_BGTZ: y = a;
			ALU_PASS_A: y = a;
			default: y = '0; // HI/LO ops and NOP
		endcase
	end

	// Signed branch conditions
	always_comb begin
		case (op)
			ALU_BEQ: branch_taken = (a == b);
			ALU_BNE: branch_taken = (a != b);
			ALU_BLTZ: branch_taken = a[DW-1];
			ALU_BGTZ: branch_taken = !a[DW-1] && (a != '0);
			default: branch_taken = 1'b0;
		endcase
	end

	assign zero = (y == '0);

endmodule

//--- logic/hilo_unit.sv
`include "exec_settings.svh"

module hilo_unit import exec_pkg::*; (
	input logic clk,
	input logic rst_n,
	input logic wr,
	input alu_op_t op,
	input logic [`EXEC_DATA_W-1:0] a,
	input logic [`EXEC_DATA_W-1:0] b,
	output logic [`EXEC_DATA_W-1:0] rd_data
);

	localparam int DW = `EXEC_DATA_W;

	logic [DW-1:0] hi;
	logic [DW-1:0] lo;
	logic signed [2*DW-1:0] prod_s;
	logic [2*DW-1:0] prod_u;
	logic signed [DW-1:0] quot_s;
	logic signed [DW-1:0] rem_s;
	logic [DW-1:0] quot_u;
	logic [DW-1:0] rem_u;
	logic div_ok;

	// Operands widened to 64 bits before the multiply
	assign prod_s = $signed({{DW{a[DW-1]}}, a}) * $signed({{DW{b[DW-1]}}, b});
	assign prod_u = {{DW{1'b0}}, a} * {{DW{1'b0}}, b};

	// Signed divide truncates toward zero and the remainder takes the dividend's sign
	assign quot_s = $signed(a) / $signed(b);
	assign rem_s = $signed(a) % $signed(b);
	assign quot_u = a / b;
	assign rem_u = a % b;

	assign div_ok = (b != '0); // Zero divisor keeps HI and LO

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			hi <= '0;
			lo <= '0;
		end else if (wr) begin
			case (op)
				ALU_MULT: begin
					hi <= prod_s[2*DW-1:DW];
					lo <= prod_s[DW-1:0];
				end
				ALU_MULTU: begin
					hi <= prod_u[2*DW-1:DW];
					lo <= prod_u[DW-1:0];
				end
				ALU_DIV: begin
					if (div_ok) begin
						hi <= rem_s;
						lo <= quot_s;
					end
				end
				ALU_DIVU: begin
					if (div_ok) begin
						hi <= rem_u;
						lo <= quot_u;
					end
				end
				default: begin
				end
			endcase
		end
	end

	// Combinational read so a move right after MULT/DIV sees new data
	assign rd_data = (op == ALU_MFHI) ? hi : lo;

endmodule

//--- logic/instr_decoder.sv
`include "exec_settings.svh"

module instr_decoder import exec_pkg::*; (
	input logic clk,
	input logic rst_n,
	input logic instr_valid,
	input instr_u instr,
	input logic [`EXEC_DATA_W-1:0] rs_val,
	input logic [`EXEC_DATA_W-1:0] rt_val,
	output issue_t issue
);

	localparam int DW = `EXEC_DATA_W;

	logic [DW-1:0] imm_sext;
	logic [DW-1:0] imm_zext;
	logic [DW-1:0] shamt_ext;
	logic [DW-1:0] rs_count;
	alu_op_t shift_op;
	issue_t issue_nxt;

	assign imm_sext = {{(DW-16){instr.i.imm[15]}}, instr.i.imm};
	assign imm_zext = {{(DW-16){1'b0}}, instr.i.imm};
	assign shamt_ext = {{(DW-5){1'b0}}, instr.r.shamt};
	assign rs_count = {{(DW-5){1'b0}}, rs_val[4:0]}; // Variable shift count

	// Funct bits [1:0] pick the shift kind for both shift groups
	assign shift_op = instr.r.funct[1] ? (instr.r.funct[0] ? ALU_SRA : ALU_SRL) : ALU_SLL;

	always_comb begin
		issue_nxt.valid = instr_valid;
		issue_nxt.op = ALU_NOP;
		issue_nxt.a = rs_val;
		issue_nxt.b = rt_val;
		issue_nxt.dest = instr.r.rd;
		issue_nxt.reg_write = 1'b0;
		issue_nxt.illegal = 1'b0;

		case (instr.r.opcode)
			`EXEC_OP_RTYPE: begin
				issue_nxt.reg_write = 1'b1;
				case (instr.r.funct)
					`EXEC_FN_AND: issue_nxt.op = ALU_AND;
					`EXEC_FN_OR: issue_nxt.op = ALU_OR;
					`EXEC_FN_XOR: issue_nxt.op = ALU_XOR;
					`EXEC_FN_ADDU: issue_nxt.op = ALU_ADD;
					`EXEC_FN_SUBU: issue_nxt.op = ALU_SUB;
					`EXEC_FN_SLT: issue_nxt.op = ALU_SLT;
					`EXEC_FN_SLTU: issue_nxt.op = ALU_SLTU;
					`EXEC_FN_MFHI: issue_nxt.op = ALU_MFHI;
					`EXEC_FN_MFLO: issue_nxt.op = ALU_MFLO;
					`EXEC_FN_SLL, `EXEC_FN_SRL, `EXEC_FN_SRA: begin
						issue_nxt.op = shift_op;
						issue_nxt.a = rt_val;
						issue_nxt.b = shamt_ext;
					end
					`EXEC_FN_SLLV, `EXEC_FN_SRLV, `EXEC_FN_SRAV: begin
						issue_nxt.op = shift_op;
						issue_nxt.a = rt_val;
						issue_nxt.b = rs_count;
					end
					`EXEC_FN_MULT, `EXEC_FN_MULTU, `EXEC_FN_DIV, `EXEC_FN_DIVU: begin
						case (instr.r.funct[1:0])
							2'b00: issue_nxt.op = ALU_MULT;
							2'b01: issue_nxt.op = ALU_MULTU;
							2'b10: issue_nxt.op = ALU_DIV;
							default: issue_nxt.op = ALU_DIVU;
						endcase
						issue_nxt.reg_write = 1'b0; // Only HI/LO change
					end
					`EXEC_FN_JR: begin
						issue_nxt.op = ALU_PASS_A;
						issue_nxt.reg_write = 1'b0;
					end
					default: begin
						issue_nxt.reg_write = 1'b0;
						issue_nxt.illegal = 1'b1;
					end
				endcase
			end
			`EXEC_OP_REGIMM: begin
				if (instr.i.rt == `EXEC_RT_BLTZ)
					issue_nxt.op = ALU_BLTZ;
				else
					issue_nxt.illegal = 1'b1;
			end
			`EXEC_OP_BEQ: issue_nxt.op = ALU_BEQ;
			`EXEC_OP_BNE: issue_nxt.op = ALU_BNE;
			`EXEC_OP_BGTZ: issue_nxt.op = ALU_BGTZ;
			`EXEC_OP_ADDIU, `EXEC_OP_SLTI, `EXEC_OP_SLTIU: begin
				case (instr.i.opcode)
					`EXEC_OP_ADDIU: issue_nxt.op = ALU_ADD;
					`EXEC_OP_SLTI: issue_nxt.op = ALU_SLT;
					default: issue_nxt.op = ALU_SLTU;
				endcase
				issue_nxt.b = imm_sext;
				issue_nxt.dest = instr.i.rt;
				issue_nxt.reg_write = 1'b1;
			end
			`EXEC_OP_ANDI, `EXEC_OP_ORI, `EXEC_OP_XORI, `EXEC_OP_LUI: begin
				case (instr.i.opcode)
					`EXEC_OP_ANDI: issue_nxt.op = ALU_AND;
					`EXEC_OP_ORI: issue_nxt.op = ALU_OR;
					`EXEC_OP_XORI: issue_nxt.op = ALU_XOR;
					default: issue_nxt.op = ALU_LUI;
				endcase
				issue_nxt.b = imm_zext;
				issue_nxt.dest = instr.i.rt;
				issue_nxt.reg_write = 1'b1;
			end
			default: issue_nxt.illegal = 1'b1;
		endcase

		issue_nxt.reg_write = issue_nxt.reg_write & instr_valid;
		issue_nxt.illegal = issue_nxt.illegal & instr_valid;
	end

	always_ff @(posedge clk) begin
		issue <= issue_nxt;
		if (!rst_n)
			issue.valid <= 1'b0;
	end

endmodule

//--- logic/exec_stage.sv
module exec_stage import exec_pkg::*; (
	input logic clk,
	input logic rst_n,
	input issue_t issue,
	output result_t result
);

	logic [$bits(issue.a)-1:0] alu_y;
	logic [$bits(issue.a)-1:0] hilo_rd;
	logic alu_zero;
	logic alu_taken;
	logic use_hilo;
	logic idle;
	result_t result_nxt;

	alu_core u_alu (
		.op(issue.op),
		.a(issue.a),
		.b(issue.b),
		.y(alu_y),
		.zero(alu_zero),
		.branch_taken(alu_taken)
	);

	hilo_unit u_hilo (
		.clk(clk),
		.rst_n(rst_n),
		.wr(issue.valid),
		.op(issue.op),
		.a(issue.a),
		.b(issue.b),
		.rd_data(hilo_rd)
	);

	assign use_hilo = (issue.op == ALU_MFHI) || (issue.op == ALU_MFLO);
	assign idle = (issue.op == ALU_NOP) || issue.illegal; // Nothing to write

	always_comb begin
		result_nxt.valid = issue.valid;
		result_nxt.dest = issue.dest;
		result_nxt.illegal = issue.illegal;
		result_nxt.branch_taken = alu_taken;
		result_nxt.reg_write = issue.reg_write & ~idle;
		if (idle) begin
			result_nxt.value = '0;
			result_nxt.zero = 1'b1;
		end else if (use_hilo) begin
			result_nxt.value = hilo_rd;
			result_nxt.zero = (hilo_rd == '0);
		end else begin
			result_nxt.value = alu_y;
			result_nxt.zero = alu_zero;
		end
	end

	always_ff @(posedge clk) begin
		result <= result_nxt;
		if (!rst_n)
			result.valid <= 1'b0;
	end

endmodule

//--- logic/exec_top.sv
`include "exec_settings.svh"

module exec_top import exec_pkg::*; (
	input logic clk,
	input logic rst_n,
	input logic instr_valid,
	input instr_u instr,
	input logic [`EXEC_DATA_W-1:0] rs_val,
	input logic [`EXEC_DATA_W-1:0] rt_val,
	output result_t result
);

	issue_t issue; // Decode to execute register

	instr_decoder u_decoder (
		.clk(clk),
		.rst_n(rst_n),
		.instr_valid(instr_valid),
		.instr(instr),
		.rs_val(rs_val),
		.rt_val(rt_val),
		.issue(issue)
	);

	exec_stage u_exec (
		.clk(clk),
		.rst_n(rst_n),
		.issue(issue),
		.result(result)
	);

endmodule

//--- testbench/exec_tb.sv
`include "exec_settings.svh"

module exec_tb import exec_pkg::*; ();
	timeunit 1ns;
	timeprecision 100ps;

	localparam int DW = `EXEC_DATA_W;
	localparam int LATENCY = 2; // Drive edge to result edge

	// Six-bit ALU encodings for the random test
	localparam logic [13*6-1:0] ALU_FNS = {`EXEC_FN_AND, `EXEC_FN_OR, `EXEC_FN_XOR,
		`EXEC_FN_ADDU, `EXEC_FN_SUBU, `EXEC_FN_SLT, `EXEC_FN_SLTU, `EXEC_FN_SLL,
		`EXEC_FN_SRL, `EXEC_FN_SRA, `EXEC_FN_SLLV, `EXEC_FN_SRLV, `EXEC_FN_SRAV};
	localparam logic [7*6-1:0] ALU_OPS = {`EXEC_OP_ADDIU, `EXEC_OP_ANDI, `EXEC_OP_ORI,
		`EXEC_OP_XORI, `EXEC_OP_SLTI, `EXEC_OP_SLTIU, `EXEC_OP_LUI};

	logic clk = 1'b0;
	logic rst_n;
	logic instr_valid;
	instr_u instr;
	logic [DW-1:0] rs_val;
	logic [DW-1:0] rt_val;
	result_t result;
	result_t exp_q[$];
	int cyc_q[$]; // Drive cycle of each expected result
	logic [DW-1:0] model_hi = '0;
	logic [DW-1:0] model_lo = '0;
	int cyc = 0;
	int err_count = 0;
	int check_count = 0;
	int test_err = 0;
	int test_chk = 0;
	bit timed_out = 1'b0;

	exec_top exec_top_i (.*);

	always #2 clk = ~clk;
	always @(posedge clk) cyc <= cyc + 1;

	// Expected result from the ISA rules and the stepped HI/LO model
	function automatic result_t ref_result(input instr_u ins, input logic [DW-1:0] rs,
		input logic [DW-1:0] rt, inout logic [DW-1:0] hi, inout logic [DW-1:0] lo);
		result_t r;
		int sa;
		int sb;
		logic [DW-1:0] simm;
		r = '0;
		r.valid = 1'b1;
		r.reg_write = 1'b1;
		sa = rs;
		sb = rt;
		simm = {{16{ins.i.imm[15]}}, ins.i.imm};
		r.dest = ins.i.rt;
		case (ins.i.opcode)
			`EXEC_OP_RTYPE: begin
				r.dest = ins.r.rd;
				case (ins.r.funct)
					`EXEC_FN_AND: r.value = rs & rt;
					`EXEC_FN_OR: r.value = rs | rt;
					`EXEC_FN_XOR: r.value = rs ^ rt;
					`EXEC_FN_ADDU: r.value = rs + rt;
					`EXEC_FN_SUBU: r.value = rs - rt;
					`EXEC_FN_SLT: r.value = DW'(sa < sb);
					`EXEC_FN_SLTU: r.value = DW'(rs < rt);
					`EXEC_FN_SLL: r.value = rt << ins.r.shamt;
					`EXEC_FN_SRL: r.value = rt >> ins.r.shamt;
					`EXEC_FN_SRA: r.value = sb >>> ins.r.shamt;
					`EXEC_FN_SLLV: r.value = rt << rs[4:0];
					`EXEC_FN_SRLV: r.value = rt >> rs[4:0];
					`EXEC_FN_SRAV: r.value = sb >>> rs[4:0];
					`EXEC_FN_MFHI: r.value = hi;
					`EXEC_FN_MFLO: r.value = lo;
					`EXEC_FN_JR: r.value = rs;
					`EXEC_FN_MULT: {hi, lo} = longint'(sa) * longint'(sb);
					`EXEC_FN_MULTU: {hi, lo} = 64'(rs) * 64'(rt);
					`EXEC_FN_DIV: if (rt != '0) {hi, lo} = {32'(sa % sb), 32'(sa / sb)};
					`EXEC_FN_DIVU: if (rt != '0) {hi, lo} = {rs % rt, rs / rt};
					default: r.illegal = 1'b1;
				endcase
				// JR and the multiply/divide group 0x18..0x1b write no register
				if (ins.r.funct == `EXEC_FN_JR || ins.r.funct[5:3] == 3'b011)
					r.reg_write = 1'b0;
			end
			`EXEC_OP_REGIMM: begin
				r.value = rs;
				r.branch_taken = (sa < 0);
				r.reg_write = 1'b0;
				r.illegal = (ins.i.rt != `EXEC_RT_BLTZ);
			end
			`EXEC_OP_BEQ: begin
				r.value = rs - rt;
				r.branch_taken = (rs == rt);
				r.reg_write = 1'b0;
			end
			`EXEC_OP_BNE: begin
				r.value = rs - rt;
				r.branch_taken = (rs != rt);
				r.reg_write = 1'b0;
			end
			`EXEC_OP_BGTZ: begin
				r.value = rs;
				r.branch_taken = (sa > 0);
				r.reg_write = 1'b0;
			end
			`EXEC_OP_ADDIU: r.value = rs + simm;
			`EXEC_OP_SLTI: r.value = DW'(sa < int'(simm));
			`EXEC_OP_SLTIU: r.value = DW'(rs < simm);
			`EXEC_OP_ANDI: r.value = rs & {16'h0, ins.i.imm};
			`EXEC_OP_ORI: r.value = rs | {16'h0, ins.i.imm};
			`EXEC_OP_XORI: r.value = rs ^ {16'h0, ins.i.imm};
			`EXEC_OP_LUI: r.value = {ins.i.imm, 16'h0};
			default: r.illegal = 1'b1;
		endcase
		if (r.illegal) begin
			r.reg_write = 1'b0;
			r.branch_taken = 1'b0;
			r.value = '0;
		end
		r.zero = (r.value == '0);
		return r;
	endfunction

	function automatic instr_u r_word(input logic [5:0] funct);
		instr_u w;
		w = instr_u'($urandom); // Random register and shift fields
		w.r.opcode = `EXEC_OP_RTYPE;
		w.r.funct = funct;
		return w;
	endfunction

	function automatic instr_u i_word(input logic [5:0] opcode);
		instr_u w;
		w = instr_u'($urandom);
		w.i.opcode = opcode;
		return w;
	endfunction

	task automatic check_result(input result_t got, input result_t exp);
		check_count++;
		if (got.value !== exp.value || got.zero !== exp.zero || got.reg_write !== exp.reg_write
			|| got.branch_taken !== exp.branch_taken || got.illegal !== exp.illegal
			|| (exp.reg_write && got.dest !== exp.dest)) begin
			err_count++;
			$display("FAIL @%0t: got/exp value %h/%h dest %0d/%0d wr %b/%b z %b/%b br %b/%b",
				$realtime, got.value, exp.value, got.dest, exp.dest, got.reg_write,
				exp.reg_write, got.zero, exp.zero, got.branch_taken, exp.branch_taken);
		end
	endtask

	// An illegal encoding writes nothing and carries a zero value
	task automatic check_illegal(input result_t got);
		check_count++;
		if (got.illegal !== 1'b1 || got.reg_write !== 1'b0 || got.value !== '0
			|| got.zero !== 1'b1 || got.branch_taken !== 1'b0) begin
			err_count++;
			$display("FAIL @%0t: illegal encoding gave illegal %b reg_write %b value %h z %b br %b",
				$realtime, got.illegal, got.reg_write, got.value, got.zero,
				got.branch_taken);
		end
	endtask

	// Results sampled at mid-cycle
	always @(negedge clk) begin
		result_t exp;
		int issued;
		if (result.valid === 1'b1) begin
			if (exp_q.size() == 0) begin
				err_count++;
				$display("FAIL @%0t: result valid with no instruction in flight", $realtime);
			end else begin
				exp = exp_q.pop_front();
				issued = cyc_q.pop_front();
				if (cyc - issued != LATENCY) begin
					err_count++;
					$display("FAIL @%0t: result after %0d cycles", $realtime, cyc - issued);
				end
				if (exp.illegal)
					check_illegal(result);
				else
					check_result(result, exp);
			end
		end
	end

	task automatic send(input instr_u ins, input logic [DW-1:0] rs, input logic [DW-1:0] rt);
		result_t exp;
		exp = ref_result(ins, rs, rt, model_hi, model_lo);
		exp_q.push_back(exp);
		cyc_q.push_back(cyc);
		instr_valid = 1'b1;
		instr = ins;
		rs_val = rs;
		rt_val = rt;
		@(posedge clk);
		#0.5;
	endtask

	task automatic finish_test(input string name);
		int waited;
		instr_valid = 1'b0;
		waited = 0;
		while (exp_q.size() != 0 && waited < 50) begin
			@(posedge clk);
			#0.5;
			waited++;
		end
		if (exp_q.size() != 0) begin
			$display("Timeout: test %s still waits for %0d results", name, exp_q.size());
			timed_out = 1'b1;
		end else begin
			$display("test %s done: %0d checks, %0d errors", name, check_count - test_chk,
				err_count - test_err);
			test_chk = check_count;
			test_err = err_count;
		end
	endtask

	task automatic run_tests();
		instr_u ins;
		logic [DW-1:0] a;
		logic [DW-1:0] b;
		int k;

		// Idle cycles must give no result
		repeat (6) @(posedge clk);
		#0.5;
		send(r_word(`EXEC_FN_ADDU), 32'h1234_5678, 32'h0fed_cba8);
		finish_test("reset_then_addu");
		if (timed_out)
			return;

		for (int n = 0; n < 300; n++) begin
			k = $urandom_range(0, 19);
			if (k < 13)
				ins = r_word(ALU_FNS[k*6 +: 6]);
			else
				ins = i_word(ALU_OPS[(k-13)*6 +: 6]);
			a = $urandom;
			b = ($urandom_range(0, 7) == 0) ? a : $urandom; // Some equal operands
			send(ins, a, b);
		end
		finish_test("random_alu");
		if (timed_out)
			return;

		// MULT, MULTU, DIV, DIVU are consecutive functs
		for (int n = 0; n < 16; n++) begin
			a = $urandom;
			b = $urandom;
			case (n / 4)
				1: a = -$urandom_range(1, 5000);
				2: b = -$urandom_range(1, 9);
				3: if (n % 4 >= 2) b = '0; // Divide by zero keeps HI and LO
				default: ;
			endcase
			send(r_word(6'(`EXEC_FN_MULT + n % 4)), a, b);
			send(r_word(`EXEC_FN_MFHI), $urandom, $urandom);
			send(r_word(`EXEC_FN_MFLO), $urandom, $urandom);
		end
		finish_test("hilo");
		if (timed_out)
			return;

		for (int n = 0; n < 24; n++) begin
			a = $urandom;
			b = $urandom;
			case (n % 6)
				1: b = a;
				2: a = '0;
				3: a = -$urandom_range(1, 100);
				4: a = $urandom_range(1, 100);
				5: a = 32'h8000_0000; // Most negative
				default: ;
			endcase
			case (n / 6)
				0: ins = i_word(`EXEC_OP_BEQ);
				1: ins = i_word(`EXEC_OP_BNE);
				2: begin
					ins = i_word(`EXEC_OP_REGIMM);
					ins.i.rt = `EXEC_RT_BLTZ;
				end
				default: ins = i_word(`EXEC_OP_BGTZ);
			endcase
			send(ins, a, b);
		end
		send(r_word(`EXEC_FN_JR), $urandom, $urandom);
		send(r_word(`EXEC_FN_JR), '0, $urandom);
		finish_test("branch_jr");
		if (timed_out)
			return;

		// Each bad encoding is followed by a normal ADDU
		for (int n = 0; n < 8; n++) begin
			case (n % 4)
				0: ins = i_word(6'h3f);
				1: ins = i_word(6'h02); // J is not in the set
				2: ins = r_word(6'h01);
				default: begin
					ins = i_word(`EXEC_OP_REGIMM);
					ins.i.rt = 5'h01; // BGEZ
				end
			endcase
			send(ins, $urandom, $urandom);
			send(r_word(`EXEC_FN_ADDU), $urandom, $urandom);
		end
		finish_test("illegal");
	endtask

	initial begin
		int seed;
		seed = 89;
		void'($urandom(seed));
		$timeformat(-9, 1, " ns", 0);
		rst_n = 1'b0;
		instr_valid = 1'b0;
		instr = '0;
		rs_val = '0;
		rt_val = '0;
		repeat (16) @(posedge clk);
		#0.5;
		rst_n = 1'b1;

		run_tests();

		$display("checks %0d, errors %0d", check_count, err_count);
		if (err_count == 0 && !timed_out)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

//--- sources.f
+incdir+logic
logic/exec_pkg.sv
logic/alu_core.sv
logic/hilo_unit.sv
logic/instr_decoder.sv
logic/exec_stage.sv
logic/exec_top.sv
testbench/exec_tb.sv
